//--- mem_cases.txt
# name op address store_data rd expected_wb_data (hex, except rd in decimal)
# Stores return their address, loads the extended lane value
alu_add            ALU                00001234 00000000 1  00001234
alu_neg            ALU                fffffff0 00000000 2  fffffff0
none_pass          NONE               0000abcd 00000000 0  0000abcd
sw_a               STORE_WORD         00000010 cafef00d 0  00000010
lw_a               LOAD_WORD          00000010 00000000 3  cafef00d
sw_pattern         STORE_WORD         00000020 11223344 0  00000020
sh_lane2           STORE_HALF         00000022 0000beef 0  00000022
sb_lane1           STORE_BYTE         00000021 123456a5 0  00000021
lw_merged          LOAD_WORD          00000020 00000000 4  beefa544
lh_lo_neg          LOAD_HALF          00000020 00000000 5  ffffa544
lhu_lo             LOAD_HALF_UNSIGNED 00000020 00000000 6  0000a544
lh_hi_neg          LOAD_HALF          00000022 00000000 7  ffffbeef
lhu_hi             LOAD_HALF_UNSIGNED 00000022 00000000 8  0000beef
lb_lane0_pos       LOAD_BYTE          00000020 00000000 9  00000044
lb_lane1_neg       LOAD_BYTE          00000021 00000000 10 ffffffa5
lbu_lane1          LOAD_BYTE_UNSIGNED 00000021 00000000 11 000000a5
lb_lane2_neg       LOAD_BYTE          00000022 00000000 12 ffffffef
lb_lane3_neg       LOAD_BYTE          00000023 00000000 13 ffffffbe
lbu_lane3          LOAD_BYTE_UNSIGNED 00000023 00000000 14 000000be
sw_pos             STORE_WORD         00000030 12345678 0  00000030
lh_hi_pos          LOAD_HALF          00000032 00000000 15 00001234
lb_lane0_pos2      LOAD_BYTE          00000030 00000000 16 00000078
alu_tail           ALU                00c0ffee 00000000 17 00c0ffee

//--- list.f
core_pkg.sv
mem_align.sv
mem_stage.sv
data_ram.sv
mem_subsystem.sv
tb_mem_subsystem.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - core_pkg.sv
  - mem_align.sv
  - mem_stage.sv
  - data_ram.sv
  - mem_subsystem.sv
  - target: test
    files:
      - tb_mem_subsystem.sv

//--- tb_mem_subsystem.sv
module tb_mem_subsystem
    import core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int MAX_CASES = 64;
    localparam int WAIT_LIMIT = 200;

    logic  cache;
    logic  rst;
    logic  in_valid;
    logic  in_ready;
    mm_t   in_data;
    logic  wb_valid;
    logic  wb_ready;
    wb_t   wb_data;
    word_t bypass;

    string     case_name [MAX_CASES];
    op_t       case_op [MAX_CASES];
    addr_t     case_addr [MAX_CASES];
    word_t     case_store [MAX_CASES];
    reg_addr_t case_rd [MAX_CASES];
    word_t     case_expect [MAX_CASES];

    int   n_cases = 0;
    int   n_out = 0;
    int   n_pass = 0;
    int   n_fail = 0;
    int   seed = 85;
    logic bp_on = 1'b0;

    mem_subsystem dut (
        .cache    (cache),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb_data  (wb_data),
        .bypass   (bypass)
    );

    initial begin
        cache = 1'b0;
        forever #50 cache = ~cache;
    end

    function automatic op_t op_from_name(input string name, output logic known);
        known = 1'b1;
        case (name)
            "NONE":               return NONE;
            "ALU":                return ALU;
            "STORE_WORD":         return STORE_WORD;
            "STORE_HALF":         return STORE_HALF;
            "STORE_BYTE":         return STORE_BYTE;
            "LOAD_WORD":          return LOAD_WORD;
            "LOAD_HALF":          return LOAD_HALF;
            "LOAD_BYTE":          return LOAD_BYTE;
            "LOAD_HALF_UNSIGNED": return LOAD_HALF_UNSIGNED;
            "LOAD_BYTE_UNSIGNED": return LOAD_BYTE_UNSIGNED;
            default: begin
                known = 1'b0;
                return NONE;
            end
        endcase
    endfunction

    task automatic load_cases();
        int        fd;
        int        code;
        string     name;
        string     op_name;
        string     rest;
        addr_t     addr;
        word_t     store;
        reg_addr_t rd;
        word_t     expect_data;
        logic      known;
        fd = $fopen("mem_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open mem_cases.txt");
            n_fail++;
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            code = $fscanf(fd, "%s", name);
            if (code != 1) break;
            if (name.substr(0, 0) == "#") begin
                // Comment lines are dropped up to their end
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%s %h %h %d %h", op_name, addr, store, rd, expect_data);
                case_op[n_cases] = op_from_name(op_name, known);
                if (code != 5 || !known) begin
                    $display("Case line %s in mem_cases.txt could not be read", name);
                    n_fail++;
                end else begin
                    case_name[n_cases] = name;
                    case_addr[n_cases] = addr;
                    case_store[n_cases] = store;
                    case_rd[n_cases] = rd;
                    case_expect[n_cases] = expect_data;
                    n_cases++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_after_reset();
        int waited;
        waited = 0;
        @(posedge cache);
        while (!in_ready && waited < WAIT_LIMIT) begin
            @(posedge cache);
            waited++;
        end
        if (!in_ready) begin
            $display("in_ready did not rise within %0d cycles after reset", WAIT_LIMIT);
            n_fail++;
        end else if (wb_valid) begin
            $display("wb_valid is high right after reset with no input sent");
            n_fail++;
        end else begin
            $display("PASS reset_state");
        end
    endtask

    task automatic send_item(input int idx, output logic sent);
        int   waited;
        mm_t  item;
        logic ld_item;
        item.op = case_op[idx];
        item.alu = case_addr[idx];
        item.rs2 = case_store[idx];
        item.rd = case_rd[idx];
        ld_item = case_op[idx] inside {LOAD_WORD, LOAD_HALF, LOAD_BYTE,
                                       LOAD_HALF_UNSIGNED, LOAD_BYTE_UNSIGNED};
        in_valid <= 1'b1;
        in_data <= item;
        waited = 0;
        sent = 1'b0;
        while (!sent && waited < WAIT_LIMIT) begin
            @(posedge cache);
            if (in_ready) sent = 1'b1;
            waited++;
        end
        if (!sent) begin
            $display("Case %s was not accepted within %0d cycles", case_name[idx], WAIT_LIMIT);
            n_fail++;
        end else if (!ld_item && bypass !== case_addr[idx]) begin
            // Outside a load the bypass carries the ALU value of the item
            $display("Mismatch %s: expected bypass %h, actual %h",
                     case_name[idx], case_addr[idx], bypass);
            n_fail++;
        end
    endtask

    task automatic check_result(input wb_t got);
        logic ok;
        ok = 1'b1;
        if (n_out >= n_cases) begin
            $display("An extra write-back item appeared after all cases were returned");
            n_fail++;
            return;
        end
        if (got.data !== case_expect[n_out]) begin
            $display("Mismatch %s: expected data %h, actual %h",
                     case_name[n_out], case_expect[n_out], got.data);
            ok = 1'b0;
        end
        if (got.op !== case_op[n_out]) begin
            $display("Mismatch %s: expected op %0d, actual %0d",
                     case_name[n_out], case_op[n_out], got.op);
            ok = 1'b0;
        end
        if (got.rd !== case_rd[n_out]) begin
            $display("Mismatch %s: expected rd %0d, actual %0d",
                     case_name[n_out], case_rd[n_out], got.rd);
            ok = 1'b0;
        end
        if (ok) begin
            $display("PASS %s", case_name[n_out]);
            n_pass++;
        end else begin
            n_fail++;
        end
        n_out++;
    endtask

    // Write-back items are taken on every edge where the stream transfers
    initial begin
        forever begin
            @(posedge cache);
            if (!rst && wb_valid && wb_ready) check_result(wb_data);
        end
    end

    initial begin
        forever begin
            @(posedge cache);
            if (bp_on) wb_ready <= ($random(seed) & 3) != 0;
        end
    end

    initial begin
        int   idx;
        int   waited;
        logic sent;
        rst = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        wb_ready = 1'b1;
        load_cases();
        repeat (4) @(posedge cache);
        rst <= 1'b0;
        check_after_reset();
        bp_on <= 1'b1;
        sent = 1'b1;
        for (idx = 0; idx < n_cases && sent; idx++) begin
            send_item(idx, sent);
        end
        in_valid <= 1'b0;
        waited = 0;
        while (n_out < n_cases && waited < WAIT_LIMIT * 4) begin
            @(posedge cache);
            waited++;
        end
        if (n_out < n_cases) begin
            $display("Only %0d of %0d results came back before the timeout", n_out, n_cases);
            n_fail++;
        end
        // A few idle cycles expose duplicated results
        repeat (8) @(posedge cache);
        $display("Cases %0d, returned %0d, passed %0d, failed %0d",
                 n_cases, n_out, n_pass, n_fail);
        if (n_fail == 0 && n_cases > 0 && n_out == n_cases) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- mem_subsystem.sv
module mem_subsystem
    import core_pkg::*;
(
    input  logic  cache,
    input  logic  rst,
    input  logic  in_valid,
    output logic  in_ready,
    input  mm_t   in_data,
    output logic  wb_valid,
    input  logic  wb_ready,
    output wb_t   wb_data,
    output word_t bypass
);

    logic    wr_valid;
    logic    wr_ready;
    mem_wr_t wr_req;
    logic    b_valid;
    logic    b_ready;
    logic    ar_valid;
    logic    ar_ready;
    addr_t   ar_addr;
    logic    r_valid;
    logic    r_ready;
    word_t   r_data;

    mem_stage u_stage (
        .cache    (cache),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb_data  (wb_data),
        .bypass   (bypass),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wr_req   (wr_req),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data)
    );

    data_ram u_ram (
        .cache    (cache),
        .rst      (rst),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wr_req   (wr_req),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data)
    );

endmodule

//--- data_ram.sv
module data_ram
    import core_pkg::*;
(
    input  logic    cache,
    input  logic    rst,
    input  logic    wr_valid,
    output logic    wr_ready,
    input  mem_wr_t wr_req,
    output logic    b_valid,
    input  logic    b_ready,
    input  logic    ar_valid,
    output logic    ar_ready,
    input  addr_t   ar_addr,
    output logic    r_valid,
    input  logic    r_ready,
    output word_t   r_data
);

    ram_state_t state;
    word_t      mem [RAM_WORDS];
    ram_idx_t   wr_idx;
    ram_idx_t   rd_idx;
    lat_cnt_t   lat_cnt;
    logic       wr_fire;
    logic       ar_fire;

    // Writes win when both channels ask in the same cycle
    assign wr_ready = (state == IDLE) && !b_valid;
    assign ar_ready = (state == IDLE) && !b_valid && !wr_valid;

    assign wr_fire = wr_valid && wr_ready;
    assign ar_fire = ar_valid && ar_ready;

    assign wr_idx = wr_req.addr[RAM_AW+1:2];

    always_ff @(posedge cache) begin
        if (rst) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_fire) begin
            for (int lane = 0; lane < $bits(strb_t); lane++) begin
                if (wr_req.strb[lane]) begin
                    mem[wr_idx][8*lane +: 8] <= wr_req.data[8*lane +: 8];
                end
            end
        end
    end

    always_ff @(posedge cache) begin
        if (rst) begin
            b_valid <= 1'b0;
        end else if (wr_fire) begin
            b_valid <= 1'b1;
        end else if (b_ready) begin
            b_valid <= 1'b0;
        end
    end

    // Read path counts the fixed latency and then holds the word until taken
    always_ff @(posedge cache) begin
        if (rst) begin
            state <= IDLE;
            lat_cnt <= '0;
            r_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (ar_fire) begin
                        lat_cnt <= lat_cnt_t'(RAM_LATENCY - 1);
                        state <= READ_WAIT;
                    end
                end
                READ_WAIT: begin
                    if (lat_cnt == '0) begin
                        r_valid <= 1'b1;
                        state <= READ_DONE;
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                READ_DONE: begin
                    if (r_ready) begin
                        r_valid <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge cache) begin
        if (ar_fire) begin
            rd_idx <= ar_addr[RAM_AW+1:2];
        end
        if ((state == READ_WAIT) && (lat_cnt == '0)) begin
            r_data <= mem[rd_idx];
        end
    end

    a_r_data_stable: assert property (@(posedge cache) disable iff (rst)
        r_valid && !r_ready |=> r_valid && $stable(r_data));

endmodule

//--- mem_stage.sv
module mem_stage
    import core_pkg::*;
(
    input  logic    cache,
    input  logic    rst,
    input  logic    in_valid,
    output logic    in_ready,
    input  mm_t     in_data,
    output logic    wb_valid,
    input  logic    wb_ready,
    output wb_t     wb_data,
    output word_t   bypass,
    output logic    wr_valid,
    input  logic    wr_ready,
    output mem_wr_t wr_req,
    input  logic    b_valid,
    output logic    b_ready,
    output logic    ar_valid,
    input  logic    ar_ready,
    output addr_t   ar_addr,
    input  logic    r_valid,
    output logic    r_ready,
    input  word_t   r_data
);

    stage_state_t state;

    logic      accept;
    logic      mem_busy;
    logic      mem_op;
    logic      load_done;
    logic      load_take;
    logic      wb_load;
    op_t       ld_op;
    addr_t     ld_addr;
    reg_addr_t ld_rd;
    word_t     ld_word;
    op_t       cur_op;
    addr_t     cur_addr;
    reg_addr_t cur_rd;
    word_t     mem_word;
    word_t     st_data;
    strb_t     st_strb;
    word_t     load_data;

    // A write still in flight blocks any further memory access
    assign mem_busy = wr_valid | b_ready;
    assign mem_op = is_load(in_data.op) | is_store(in_data.op);

    assign in_ready = (state == RUN) && wb_ready && !(mem_busy && mem_op);
    assign accept = in_valid && in_ready;

    // Returned load data moves to write-back once the output register is free
    assign load_take = (state == LOAD_WAIT) && load_done && (!wb_valid || wb_ready);
    assign wb_load = (accept && !is_load(in_data.op)) || load_take;

    // While a load is open the aligner works on the held load
    assign cur_op = (state == LOAD_WAIT) ? ld_op : in_data.op;
    assign cur_addr = (state == LOAD_WAIT) ? ld_addr : in_data.alu;
    assign cur_rd = (state == LOAD_WAIT) ? ld_rd : in_data.rd;
    assign mem_word = load_done ? ld_word : r_data;

    mem_align u_align (
        .op         (cur_op),
        .addr       (cur_addr),
        .store_data (in_data.rs2),
        .mem_data   (mem_word),
        .wr_data    (st_data),
        .wr_strb    (st_strb),
        .load_data  (load_data)
    );

    assign bypass = (state == LOAD_WAIT) ? load_data : in_data.alu;

    always_ff @(posedge cache) begin
        if (rst) begin
            state <= RUN;
        end else begin
            case (state)
                RUN:       if (accept && is_load(in_data.op)) state <= LOAD_WAIT;
                LOAD_WAIT: if (load_take) state <= RUN;
                default:   state <= RUN;
            endcase
        end
    end

    always_ff @(posedge cache) begin
        if (rst) begin
            load_done <= 1'b0;
        end else if (r_valid && r_ready) begin
            load_done <= 1'b1;
        end else if (load_take) begin
            load_done <= 1'b0;
        end
    end

    always_ff @(posedge cache) begin
        if (accept && is_load(in_data.op)) begin
            ld_op <= in_data.op;
            ld_addr <= in_data.alu;
            ld_rd <= in_data.rd;
            ar_addr <= in_data.alu;
        end
        if (r_valid && r_ready) begin
            ld_word <= r_data;
        end
        if (accept && is_store(in_data.op)) begin
            wr_req <= '{addr: in_data.alu, data: st_data, strb: st_strb};
        end
        if (wb_load) begin
            wb_data <= '{op: cur_op, rd: cur_rd, data: bypass};
        end
    end

    // Request and handshake flags for both memory channels
    always_ff @(posedge cache) begin
        if (rst) begin
            wr_valid <= 1'b0;
            b_ready <= 1'b0;
            ar_valid <= 1'b0;
            r_ready <= 1'b0;
        end else begin
            if (accept && is_store(in_data.op)) begin
                wr_valid <= 1'b1;
                b_ready <= 1'b1;
            end else begin
                if (wr_valid && wr_ready) wr_valid <= 1'b0;
                if (b_valid) b_ready <= 1'b0;
            end
            if (accept && is_load(in_data.op)) begin
                ar_valid <= 1'b1;
                r_ready <= 1'b1;
            end else begin
                if (ar_valid && ar_ready) ar_valid <= 1'b0;
                if (r_valid) r_ready <= 1'b0;
            end
        end
    end

    always_ff @(posedge cache) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else if (wb_load) begin
            wb_valid <= 1'b1;
        end else if (wb_ready) begin
            wb_valid <= 1'b0;
        end
    end

    // The memory serves one request at a time
    a_one_request: assert property (@(posedge cache) disable iff (rst)
        !(wr_valid && ar_valid));

    // No new item may enter while a read is still outstanding
    a_load_blocks_input: assert property (@(posedge cache) disable iff (rst)
        (ar_valid || r_ready || load_done) |-> !in_ready);

endmodule

//--- mem_align.sv
module mem_align
    import core_pkg::*;
(
    input  op_t   op,
    input  addr_t addr,
    input  word_t store_data,
    input  word_t mem_data,
    output word_t wr_data,
    output strb_t wr_strb,
    output word_t load_data
);

    logic [4:0] lane_shift;
    word_t      lane_word;
    logic       aligned;

    // Bit offset of the addressed byte lane
    assign lane_shift = {addr[1:0], 3'b000};

    // Aligned stores only, so a plain shift puts every size in its lane
    assign wr_data = store_data << lane_shift;

    always_comb begin
        case (op)
            STORE_WORD: wr_strb = 4'b1111;
            STORE_HALF: wr_strb = 4'b0011 << addr[1:0];
            STORE_BYTE: wr_strb = 4'b0001 << addr[1:0];
            default:    wr_strb = '0;
        endcase
    end

    // Bring the addressed lane down to bit 0 before extension
    assign lane_word = mem_data >> lane_shift;

    always_comb begin
        case (op)
            LOAD_HALF:          load_data = {{16{lane_word[15]}}, lane_word[15:0]};
            LOAD_BYTE:          load_data = {{24{lane_word[7]}}, lane_word[7:0]};
            LOAD_HALF_UNSIGNED: load_data = {16'h0000, lane_word[15:0]};
            LOAD_BYTE_UNSIGNED: load_data = {24'h000000, lane_word[7:0]};
            default:            load_data = mem_data;  // word loads
        endcase
    end

    assign aligned = (op == STORE_WORD) ? (addr[1:0] == 2'b00) :
                     (op == STORE_HALF) ? !addr[0] : 1'b1;

    // Misaligned accesses have no defined result
    always_comb begin
        if (!$isunknown(op) && is_store(op)) begin
            a_store_aligned: assert final (aligned)
                else $error("Misaligned store of op %s to address %h", op.name(), addr);
        end
    end

endmodule

//--- core_pkg.sv
package core_pkg;

    // Memory geometry
    localparam int RAM_WORDS = 256;
    localparam int RAM_LATENCY = 2;
    localparam int RAM_AW = $clog2(RAM_WORDS);
    localparam int RAM_LAT_W = $clog2(RAM_LATENCY + 1);

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strb_t;
    typedef logic [4:0]  reg_addr_t;

    typedef logic [RAM_AW-1:0]    ram_idx_t;
    typedef logic [RAM_LAT_W-1:0] lat_cnt_t;

    // Operation classes seen by the memory stage
    typedef enum logic [3:0] {
        NONE,
        ALU,
        STORE_WORD,
        STORE_HALF,
        STORE_BYTE,
        LOAD_WORD,
        LOAD_HALF,
        LOAD_BYTE,
        LOAD_HALF_UNSIGNED,
        LOAD_BYTE_UNSIGNED
    } op_t;

    // Executed instruction entering the stage
    typedef struct packed {
        op_t       op;
        word_t     alu;
        word_t     rs2;
        reg_addr_t rd;
    } mm_t;

    // Result leaving the stage for write-back
    typedef struct packed {
        op_t       op;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    // Merged write address and write data
    typedef struct packed {
        addr_t addr;
        word_t data;
        strb_t strb;
    } mem_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        READ_WAIT,
        READ_DONE
    } ram_state_t;

    typedef enum logic {
        RUN,
        LOAD_WAIT
    } stage_state_t;

    function automatic logic is_load(op_t op);
        return op inside {LOAD_WORD, LOAD_HALF, LOAD_BYTE,
                          LOAD_HALF_UNSIGNED, LOAD_BYTE_UNSIGNED};
    endfunction

    function automatic logic is_store(op_t op);
        return op inside {STORE_WORD, STORE_HALF, STORE_BYTE};
    endfunction

endpackage
